//--- logic/ai_consts.svh
`ifndef AI_CONSTS_SVH
`define AI_CONSTS_SVH

//////////////////////////////
// shared memory
//////////////////////////////

// word address into the shared memory
`define AI_ADDR_W 10
`define AI_DATA_W 32
`define AI_MEM_WORDS 1024

// every length field, wide enough for a full weight block
`define AI_LEN_W 9

//////////////////////////////
// local buffers
//////////////////////////////

`define AI_IFM_DEPTH 16
`define AI_WGT_DEPTH 256
`define AI_OFM_DEPTH 16

`endif

//--- logic/ai_pkg.sv
`default_nettype none

package ai_pkg;

    // control unit steps for one layer
    typedef enum logic [2:0] {
        cu_idle,
        cu_fetch,
        cu_start_seq,
        cu_wait_seq,
        cu_writeback,
        cu_done
    } cu_state_t;

    // one output per clear/mac.../store round
    typedef enum logic [1:0] {
        seq_idle,
        seq_clear,
        seq_mac,
        seq_store
    } seq_state_t;

    // burst direction, seen from the shared memory
    typedef enum logic {
        mem_rd,
        mem_wr
    } mem_dir_t;

    // target of a buffer access
    typedef enum logic [1:0] {
        buf_ifm,
        buf_wgt,
        buf_ofm
    } buf_sel_t;

endpackage

`default_nettype wire

//--- logic/ai_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "ai_consts.svh"

interface ai_mem_if;

    // level request, held with stable fields until done
    logic                  req;
    ai_pkg::mem_dir_t      dir;
    logic [`AI_ADDR_W-1:0] addr_a;
    logic [`AI_LEN_W-1:0]  len_a;
    // second pair, only used by reads (weights)
    logic [`AI_ADDR_W-1:0] addr_b;
    logic [`AI_LEN_W-1:0]  len_b;
    logic                  done;

    modport cu (
        output req, dir, addr_a, len_a, addr_b, len_b,
        input  done
    );

    modport mc (
        input  req, dir, addr_a, len_a, addr_b, len_b,
        output done
    );

endinterface

`default_nettype wire

//--- logic/ai_seq_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "ai_consts.svh"

interface ai_seq_if;

    // control part, start is a single-cycle pulse
    logic                  start;
    logic [`AI_LEN_W-1:0]  ifm_len;
    logic [`AI_LEN_W-1:0]  ofm_len;
    logic                  done;

    // buffer part, ofm read data lags the address by one cycle
    logic                  buf_wr_en;
    ai_pkg::buf_sel_t      buf_sel;
    logic [`AI_LEN_W-1:0]  buf_addr;
    logic [`AI_DATA_W-1:0] buf_wdata;
    logic [`AI_DATA_W-1:0] buf_rdata;

    modport cu (
        output start, ifm_len, ofm_len,
        input  done
    );

    modport seq (
        input  start, ifm_len, ofm_len,
        output done
    );

    modport mc (
        output buf_wr_en, buf_sel, buf_addr, buf_wdata,
        input  buf_rdata
    );

    // buffer owner side
    modport lbuf (
        input  buf_wr_en, buf_sel, buf_addr, buf_wdata,
        output buf_rdata
    );

endinterface

`default_nettype wire

//--- logic/ai_cu_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "ai_consts.svh"

module ai_cu_fsm (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  start,
    input  wire logic [`AI_ADDR_W-1:0] ifm_base,
    input  wire logic [`AI_ADDR_W-1:0] wgt_base,
    input  wire logic [`AI_ADDR_W-1:0] ofm_base,
    input  wire logic [`AI_LEN_W-1:0]  ifm_len,
    input  wire logic [`AI_LEN_W-1:0]  ofm_len,
    ai_mem_if.cu                       mem,
    ai_seq_if.cu                       seq,
    output logic                       busy,
    output logic                       phase_fetch,
    output logic                       phase_compute,
    output logic                       phase_writeback,
    output logic                       layer_done
);

    localparam int LW = `AI_LEN_W;

    ai_pkg::cu_state_t     state;

    logic [`AI_ADDR_W-1:0] ifm_base_q;
    logic [`AI_ADDR_W-1:0] wgt_base_q;
    logic [`AI_ADDR_W-1:0] ofm_base_q;
    logic [LW-1:0]         ifm_len_q;
    logic [LW-1:0]         ofm_len_q;
    logic [LW-1:0]         wgt_len_q;
    logic [2*LW-1:0]       wgt_len_full;

    // one weight row per output
    assign wgt_len_full = ifm_len * ofm_len;

    //////////////////////////////
    // configuration latch
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (state == ai_pkg::cu_idle && start) begin
            ifm_base_q <= ifm_base;
            wgt_base_q <= wgt_base;
            ofm_base_q <= ofm_base;
            ifm_len_q  <= ifm_len;
            ofm_len_q  <= ofm_len;
            wgt_len_q  <= wgt_len_full[LW-1:0];
        end
    end

    //////////////////////////////
    // layer steps
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ai_pkg::cu_idle;
        end else begin
            case (state)
                ai_pkg::cu_idle:      if (start) state <= ai_pkg::cu_fetch;
                ai_pkg::cu_fetch:     if (mem.done) state <= ai_pkg::cu_start_seq;
                ai_pkg::cu_start_seq: state <= ai_pkg::cu_wait_seq;
                ai_pkg::cu_wait_seq:  if (seq.done) state <= ai_pkg::cu_writeback;
                ai_pkg::cu_writeback: if (mem.done) state <= ai_pkg::cu_done;
                ai_pkg::cu_done:      state <= ai_pkg::cu_idle;
                default:              state <= ai_pkg::cu_idle;
            endcase
        end
    end

    assign phase_fetch     = (state == ai_pkg::cu_fetch);
    // the start pulse cycle counts as compute
    assign phase_compute   = (state == ai_pkg::cu_start_seq) || (state == ai_pkg::cu_wait_seq);
    assign phase_writeback = (state == ai_pkg::cu_writeback);
    assign layer_done      = (state == ai_pkg::cu_done);
    assign busy            = (state != ai_pkg::cu_idle) && !layer_done;

    // memory request: ifm+wgt pair on fetch, ofm on writeback
    assign mem.req    = phase_fetch || phase_writeback;
    assign mem.dir    = phase_writeback ? ai_pkg::mem_wr : ai_pkg::mem_rd;
    assign mem.addr_a = phase_writeback ? ofm_base_q : ifm_base_q;
    assign mem.len_a  = phase_writeback ? ofm_len_q : ifm_len_q;
    assign mem.addr_b = wgt_base_q;
    assign mem.len_b  = wgt_len_q;

    assign seq.start   = (state == ai_pkg::cu_start_seq);
    assign seq.ifm_len = ifm_len_q;
    assign seq.ofm_len = ofm_len_q;

    //////////////////////////////
    // checks
    //////////////////////////////

    phase_onehot_a: assert property (@(posedge clk) disable iff (rst)
        $onehot0({phase_fetch, phase_compute, phase_writeback}));

    // a request only follows a start or the end of compute
    req_rise_a: assert property (@(posedge clk) disable iff (rst)
        $rose(mem.req) |-> $past(start) || $past(seq.done));

endmodule

`default_nettype wire

//--- logic/ai_mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "ai_consts.svh"

module ai_mem_ctrl (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  host_wr_en,
    input  wire logic [`AI_ADDR_W-1:0] host_addr,
    input  wire logic [`AI_DATA_W-1:0] host_wdata,
    output logic      [`AI_DATA_W-1:0] host_rdata,
    ai_mem_if.mc                       mem,
    ai_seq_if.mc                       bufp
);

    localparam int AW = `AI_ADDR_W;
    localparam int DW = `AI_DATA_W;
    localparam int LW = `AI_LEN_W;

    logic [DW-1:0] mem_q [0:`AI_MEM_WORDS-1];

    logic          active;
    logic          second;
    logic [AW-1:0] addr;
    logic [LW-1:0] cnt;
    logic          wr_pend;
    logic          wr_last;
    logic [AW-1:0] wr_addr;
    logic          is_read;
    logic          last_word;
    logic          rd_done;
    logic          wr_done;

    assign is_read   = (mem.dir == ai_pkg::mem_rd);
    assign last_word = (cnt == LW'(1));

    // read ends on the last wgt word, write one cycle after the last ofm read
    assign rd_done  = active && is_read && second && last_word;
    assign wr_done  = wr_pend && wr_last;
    assign mem.done = rd_done || wr_done;

    //////////////////////////////
    // burst engine
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            second <= 1'b0;
            addr   <= '0;
            cnt    <= '0;
        end else if (!active) begin
            // wr_pend covers the done cycle of a write, where req is still up
            if (mem.req && !wr_pend) begin
                active <= 1'b1;
                second <= 1'b0;
                addr   <= mem.addr_a;
                cnt    <= mem.len_a;
            end
        end else begin
            addr <= addr + AW'(1);
            cnt  <= cnt - LW'(1);
            if (last_word) begin
                if (is_read && !second) begin
                    // straight on to the weights, no bubble
                    second <= 1'b1;
                    addr   <= mem.addr_b;
                    cnt    <= mem.len_b;
                end else begin
                    active <= 1'b0;
                end
            end
        end
    end

    // ofm word arrives one cycle after its buffer address
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_pend <= 1'b0;
            wr_last <= 1'b0;
        end else begin
            wr_pend <= active && !is_read;
            wr_last <= active && last_word;
        end
    end

    always_ff @(posedge clk) begin
        wr_addr <= addr;
    end

    // buffer side, index within the current pair
    assign bufp.buf_wr_en = active && is_read;
    assign bufp.buf_sel   = !is_read ? ai_pkg::buf_ofm :
                            (second ? ai_pkg::buf_wgt : ai_pkg::buf_ifm);
    assign bufp.buf_addr  = (second ? mem.len_b : mem.len_a) - cnt;
    assign bufp.buf_wdata = mem_q[addr];

    //////////////////////////////
    // shared memory
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (host_wr_en) begin
            mem_q[host_addr] <= host_wdata;
        end else if (wr_pend) begin
            mem_q[wr_addr] <= bufp.buf_rdata;
        end
        host_rdata <= mem_q[host_addr];
    end

    host_wr_idle_a: assert property (@(posedge clk) disable iff (rst)
        mem.req |-> !host_wr_en);

    rd_len_a: assert property (@(posedge clk) disable iff (rst)
        (mem.req && !active && !wr_pend && is_read) |->
            (mem.len_a != '0) && (mem.len_b != '0));

endmodule

`default_nettype wire

//--- logic/ai_mac_seq.sv
`timescale 1ns/1ps
`default_nettype none

`include "ai_consts.svh"

module ai_mac_seq (
    input  wire logic clk,
    input  wire logic rst,
    ai_seq_if.seq     seq,
    ai_seq_if.lbuf    bufp
);

    localparam int LW     = `AI_LEN_W;
    localparam int DW     = `AI_DATA_W;
    localparam int EW     = 16;
    localparam int IFM_AW = $clog2(`AI_IFM_DEPTH);
    localparam int WGT_AW = $clog2(`AI_WGT_DEPTH);
    localparam int OFM_AW = $clog2(`AI_OFM_DEPTH);

    // elements are the signed low half of each memory word
    logic signed [EW-1:0] ifm_buf [0:`AI_IFM_DEPTH-1];
    logic signed [EW-1:0] wgt_buf [0:`AI_WGT_DEPTH-1];
    logic        [DW-1:0] ofm_buf [0:`AI_OFM_DEPTH-1];

    ai_pkg::seq_state_t   state;
    logic [LW-1:0]        i_idx;
    logic [LW-1:0]        k_idx;
    logic [LW-1:0]        w_ptr;
    logic signed [DW-1:0] acc;
    logic signed [DW-1:0] prod;
    logic                 last_in;
    logic                 last_out;

    assign last_in  = (i_idx == seq.ifm_len - LW'(1));
    assign last_out = (k_idx == seq.ofm_len - LW'(1));

    // w_ptr walks k*ifm_len+i without a multiplier
    assign prod = ifm_buf[i_idx[IFM_AW-1:0]] * wgt_buf[w_ptr[WGT_AW-1:0]];

    assign seq.done = (state == ai_pkg::seq_store) && last_out;

    //////////////////////////////
    // sequencer
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ai_pkg::seq_idle;
            i_idx <= '0;
            k_idx <= '0;
            w_ptr <= '0;
            acc   <= '0;
        end else begin
            case (state)
                ai_pkg::seq_idle: begin
                    if (seq.start) begin
                        k_idx <= '0;
                        w_ptr <= '0;
                        state <= ai_pkg::seq_clear;
                    end
                end
                ai_pkg::seq_clear: begin
                    acc   <= '0;
                    i_idx <= '0;
                    state <= ai_pkg::seq_mac;
                end
                ai_pkg::seq_mac: begin
                    // wraps at 32 bits
                    acc   <= acc + prod;
                    i_idx <= i_idx + LW'(1);
                    w_ptr <= w_ptr + LW'(1);
                    if (last_in) begin
                        state <= ai_pkg::seq_store;
                    end
                end
                ai_pkg::seq_store: begin
                    if (last_out) begin
                        state <= ai_pkg::seq_idle;
                    end else begin
                        k_idx <= k_idx + LW'(1);
                        state <= ai_pkg::seq_clear;
                    end
                end
                default: state <= ai_pkg::seq_idle;
            endcase
        end
    end

    //////////////////////////////
    // local buffers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (bufp.buf_wr_en && bufp.buf_sel == ai_pkg::buf_ifm) begin
            ifm_buf[bufp.buf_addr[IFM_AW-1:0]] <= bufp.buf_wdata[EW-1:0];
        end
        if (bufp.buf_wr_en && bufp.buf_sel == ai_pkg::buf_wgt) begin
            wgt_buf[bufp.buf_addr[WGT_AW-1:0]] <= bufp.buf_wdata[EW-1:0];
        end
        if (state == ai_pkg::seq_store) begin
            ofm_buf[k_idx[OFM_AW-1:0]] <= acc;
        end
        // writeback read port
        bufp.buf_rdata <= ofm_buf[bufp.buf_addr[OFM_AW-1:0]];
    end

    wgt_fit_a: assert property (@(posedge clk) disable iff (rst)
        seq.start |-> (seq.ifm_len * seq.ofm_len) <= `AI_WGT_DEPTH);

endmodule

`default_nettype wire

//--- logic/ai_layer_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ai_consts.svh"

module ai_layer_top (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  start,
    input  wire logic                  host_wr_en,
    input  wire logic [`AI_ADDR_W-1:0] host_addr,
    input  wire logic [`AI_DATA_W-1:0] host_wdata,
    input  wire logic [`AI_ADDR_W-1:0] ifm_base,
    input  wire logic [`AI_ADDR_W-1:0] wgt_base,
    input  wire logic [`AI_ADDR_W-1:0] ofm_base,
    input  wire logic [`AI_LEN_W-1:0]  ifm_len,
    input  wire logic [`AI_LEN_W-1:0]  ofm_len,
    output logic      [`AI_DATA_W-1:0] host_rdata,
    output logic                       busy,
    output logic                       phase_fetch,
    output logic                       phase_compute,
    output logic                       phase_writeback,
    output logic                       layer_done
);

    // control unit to memory controller
    ai_mem_if mem_bus ();
    // control unit to sequencer, memory controller to local buffers
    ai_seq_if seq_bus ();

    ai_cu_fsm cu_i (
        .clk             (clk),
        .rst             (rst),
        .start           (start),
        .ifm_base        (ifm_base),
        .wgt_base        (wgt_base),
        .ofm_base        (ofm_base),
        .ifm_len         (ifm_len),
        .ofm_len         (ofm_len),
        .mem             (mem_bus.cu),
        .seq             (seq_bus.cu),
        .busy            (busy),
        .phase_fetch     (phase_fetch),
        .phase_compute   (phase_compute),
        .phase_writeback (phase_writeback),
        .layer_done      (layer_done)
    );

    ai_mem_ctrl mc_i (
        .clk        (clk),
        .rst        (rst),
        .host_wr_en (host_wr_en),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .mem        (mem_bus.mc),
        .bufp       (seq_bus.mc)
    );

    ai_mac_seq seq_i (
        .clk  (clk),
        .rst  (rst),
        .seq  (seq_bus.seq),
        .bufp (seq_bus.lbuf)
    );

endmodule

`default_nettype wire

//--- verification/ai_layer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ai_consts.svh"

module ai_layer_tb;

    localparam int MEM   = `AI_MEM_WORDS;
    localparam int LIMIT = 2000;

    logic                  clk;
    logic                  rst;
    logic                  start;
    logic                  host_wr_en;
    logic [`AI_ADDR_W-1:0] host_addr;
    logic [`AI_DATA_W-1:0] host_wdata;
    logic [`AI_ADDR_W-1:0] ifm_base;
    logic [`AI_ADDR_W-1:0] wgt_base;
    logic [`AI_ADDR_W-1:0] ofm_base;
    logic [`AI_LEN_W-1:0]  ifm_len;
    logic [`AI_LEN_W-1:0]  ofm_len;
    logic [`AI_DATA_W-1:0] host_rdata;
    logic                  busy;
    logic                  phase_fetch;
    logic                  phase_compute;
    logic                  phase_writeback;
    logic                  layer_done;

    // expected memory contents
    logic [31:0] image [0:MEM-1];
    logic [31:0] lfsr;
    logic        chk_on;
    logic [31:0] chk_exp;
    int          chk_addr;
    logic        run_open;

    ai_layer_top ai_layer_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    //////////////////////////////
    // checks
    //////////////////////////////

    // read data lags host_addr by one cycle
    rdata_a: assert property (@(posedge clk) disable iff (rst) chk_on |-> host_rdata == chk_exp)
        else fail_run($sformatf("error at %0t: host_rdata word %0d got %h expected %h", $time,
            $sampled(chk_addr), $sampled(host_rdata), $sampled(chk_exp)));
    done_pulse_a: assert property (@(posedge clk) disable iff (rst)
        $past(layer_done) |-> !layer_done)
        else fail_run("layer_done stayed high for more than one cycle");
    done_busy_a: assert property (@(posedge clk) disable iff (rst)
        layer_done |-> !busy && $past(busy) && $past(phase_writeback))
        else fail_run("layer_done did not end a writeback with busy falling");
    busy_fall_a: assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> layer_done)
        else fail_run("busy fell without layer_done");
    onehot_a: assert property (@(posedge clk) disable iff (rst)
        $onehot0({phase_fetch, phase_compute, phase_writeback}))
        else fail_run("more than one phase strobe high");
    in_busy_a: assert property (@(posedge clk) disable iff (rst)
        (phase_fetch || phase_compute || phase_writeback) |-> busy)
        else fail_run("phase strobe high while not busy");
    fetch_first_a: assert property (@(posedge clk) disable iff (rst)
        $rose(phase_fetch) |-> $rose(busy))
        else fail_run("fetch phase did not open the layer");
    compute_order_a: assert property (@(posedge clk) disable iff (rst)
        $rose(phase_compute) |-> $past(phase_fetch))
        else fail_run("compute phase did not follow fetch");
    wb_order_a: assert property (@(posedge clk) disable iff (rst)
        $rose(phase_writeback) |-> $past(phase_compute))
        else fail_run("writeback phase did not follow compute");
    one_layer_a: assert property (@(posedge clk) disable iff (rst)
        ($rose(busy) || layer_done) |-> run_open)
        else fail_run("a layer started or ended without a start from idle");
    reset_low_a: assert property (@(posedge clk)
        $fell(rst) |-> !(busy || phase_fetch || phase_compute || phase_writeback || layer_done))
        else fail_run("status outputs not low after reset");

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // right-shift Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    task automatic load_memory();
        for (int a = 0; a < MEM; a++) begin
            image[a]   = next_bits(32);
            host_wr_en = 1'b1;
            host_addr  = `AI_ADDR_W'(a);
            host_wdata = image[a];
            step();
        end
        host_wr_en = 1'b0;
    endtask

    // every word is compared, ofm region and the rest
    task automatic sweep_memory();
        for (int a = 0; a <= MEM; a++) begin
            if (a < MEM) host_addr = `AI_ADDR_W'(a);
            chk_on = (a > 0);
            if (a > 0) begin
                chk_exp  = image[a-1];
                chk_addr = a - 1;
            end
            step();
        end
        chk_on = 1'b0;
    endtask

    // out[k] = sum of ifm[i] * wgt[k*il+i], low halves signed, 32-bit wrap
    task automatic apply_reference(input int ib, input int wb, input int ob,
                                   input int il, input int ol);
        logic signed [15:0] x;
        logic signed [15:0] w;
        logic signed [31:0] sum;
        logic [31:0]        res [16];
        for (int k = 0; k < ol; k++) begin
            sum = '0;
            for (int i = 0; i < il; i++) begin
                x   = image[ib+i][15:0];
                w   = image[wb+k*il+i][15:0];
                sum = sum + x * w;
            end
            res[k] = sum;
        end
        for (int k = 0; k < ol; k++) image[ob+k] = res[k];
    endtask

    task automatic launch(input int ib, input int wb, input int ob, input int il, input int ol);
        ifm_base = `AI_ADDR_W'(ib);
        wgt_base = `AI_ADDR_W'(wb);
        ofm_base = `AI_ADDR_W'(ob);
        ifm_len  = `AI_LEN_W'(il);
        ofm_len  = `AI_LEN_W'(ol);
        start    = 1'b1;
        run_open = 1'b1;
        step();
        start = 1'b0;
    endtask

    task automatic wait_compute();
        int n;
        n = 0;
        while (!phase_compute) begin
            if (n == LIMIT) fail_run("timeout waiting for the compute phase");
            step();
            n++;
        end
    endtask

    task automatic run_layer(input int il_fix, input int ol_fix, input bit poke);
        int il;
        int ol;
        int ib;
        int wb;
        int ob;
        int n;
        il = (il_fix != 0) ? il_fix : int'(next_bits(4)) + 1;
        ol = (ol_fix != 0) ? ol_fix : int'(next_bits(4)) + 1;
        ib = int'(next_bits(10)) % (MEM - 16);
        wb = int'(next_bits(10)) % (MEM - 256);
        ob = int'(next_bits(10)) % (MEM - 16);
        launch(ib, wb, ob, il, ol);
        if (poke) begin
            wait_compute();
            // second start with another shape, must be ignored
            launch(ob, 0, ib, 16, 16);
        end
        n = 0;
        while (!layer_done) begin
            if (n == LIMIT) fail_run("timeout waiting for layer_done");
            step();
            n++;
        end
        step();
        run_open = 1'b0;
        apply_reference(ib, wb, ob, il, ol);
        sweep_memory();
    endtask

    // reset lands in compute, so memory is untouched
    task automatic abort_layer();
        launch(int'(next_bits(9)), int'(next_bits(9)), int'(next_bits(9)), 8, 8);
        wait_compute();
        step();
        rst      = 1'b1;
        run_open = 1'b0;
        repeat (3) step();
        rst = 1'b0;
        step();
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        lfsr       = 32'hc123_0305;
        rst        = 1'b1;
        start      = 1'b0;
        host_wr_en = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        ifm_base   = '0;
        wgt_base   = '0;
        ofm_base   = '0;
        ifm_len    = `AI_LEN_W'(1);
        ofm_len    = `AI_LEN_W'(1);
        chk_on     = 1'b0;
        chk_exp    = '0;
        chk_addr   = 0;
        run_open   = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        load_memory();
        run_layer(1, 0, 1'b0);
        run_layer(0, 1, 1'b0);
        run_layer(16, 16, 1'b0);
        run_layer(0, 0, 1'b1);
        run_layer(0, 0, 1'b0);
        abort_layer();
        run_layer(0, 0, 1'b0);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+logic
logic/ai_pkg.sv
logic/ai_mem_if.sv
logic/ai_seq_if.sv
logic/ai_cu_fsm.sv
logic/ai_mem_ctrl.sv
logic/ai_mac_seq.sv
logic/ai_layer_top.sv
verification/ai_layer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the layer engine testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module ai_layer_tb -o ai_layer_sim

# the testbench stops with a nonzero status on failure, the log decides
./obj_dir/ai_layer_sim | tee sim.log

if grep -q "^TEST OK$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
